// File: list.f
+incdir+include
hdl/mem_msg_pkg.sv
hdl/wb_bus_pkg.sv
hdl/one_entry_if.sv
hdl/one_entry_buffer.sv
hdl/resp_data_pack.sv
hdl/ack_wait_timer.sv
hdl/wb_cycle_fsm.sv
hdl/wb_master_bridge.sv
testbench/wb_slave_model.sv
testbench/tb_wb_master_bridge.sv

// File: run_sim.sh
#!/bin/sh
# builds the bridge testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wb_master_bridge -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_wb_master_bridge > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: testbench/tb_wb_master_bridge.sv
/* model memory mirrors the 256 words of the slave model
   narrow accesses always use the low byte lanes of the addressed word */
`timescale 1ns/1ps
`include "wb_bridge_consts.svh"

module tb_wb_master_bridge;

  import mem_msg_pkg::*;
  import wb_bus_pkg::*;

  localparam int unsigned depth_lp = 256;
  localparam int unsigned wait_limit_lp = 64;

  typedef struct packed {
    mem_header_s header;
    wb_word_t    data;
    logic        err;
    logic        data_known;
  } exp_resp_s;

  logic        clk_i, reset_i, hang;
  mem_header_s mem_cmd_header_i, mem_resp_header_o;
  wb_word_t    mem_cmd_data_i, mem_resp_data_o, dat_o, dat_i;
  logic        mem_cmd_v_i, mem_cmd_ready_o, mem_resp_err_o, mem_resp_v_o, mem_resp_yumi_i;
  wb_adr_t     adr_o;
  wb_sel_t     sel_o;
  logic        we_o, cyc_o, stb_o, ack_i, cyc_q;

  wb_word_t    model_mem [depth_lp];
  exp_resp_s   exp_q [$];
  wb_sel_t     exp_sel;
  wb_adr_t     exp_adr;
  logic        exp_we;
  wb_word_t    exp_dat;
  string       test_name;
  int          mismatches = 0, protocol_errors = 0, timeouts = 0;
  int          accepted, bus_cycles, stb_run, last_stb_len;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  wb_master_bridge u_dut (.*);

  wb_slave_model #(.depth_p(depth_lp)) u_slave (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .hang_i (hang),
    .cyc_i  (cyc_o),
    .stb_i  (stb_o),
    .we_i   (we_o),
    .adr_i  (adr_o),
    .sel_i  (sel_o),
    .dat_i  (dat_o),
    .dat_o  (dat_i),
    .ack_o  (ack_i)
  );

  assert property (@(posedge clk_i) disable iff (reset_i) stb_o |-> cyc_o)
    else begin
      protocol_errors++;
      $display("protocol error: stb_o high without cyc_o");
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    stb_o |-> (sel_o == exp_sel) && (adr_o == exp_adr))
    else begin
      mismatches++;
      $display("mismatch [%s] sel/adr: expected %h/%h, actual %h/%h",
               test_name, exp_sel, exp_adr, sel_o, adr_o);
    end

  // write data only matters on write cycles
  assert property (@(posedge clk_i) disable iff (reset_i)
    stb_o |-> (we_o == exp_we) && (!exp_we || (dat_o == exp_dat)))
    else begin
      mismatches++;
      $display("mismatch [%s] we/dat: expected %b/%h, actual %b/%h",
               test_name, exp_we, exp_dat, we_o, dat_o);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_resp_v_o && !mem_resp_yumi_i) |=>
      (mem_resp_v_o && $stable(mem_resp_data_o) && $stable(mem_resp_err_o)))
    else begin
      protocol_errors++;
      $display("protocol error: response changed before yumi");
    end

  // ready stays low from accept up to the yumi edge
  assert property (@(posedge clk_i) disable iff (reset_i)
    ((mem_cmd_v_i && mem_cmd_ready_o) || (!mem_cmd_ready_o && !mem_resp_yumi_i))
      |=> !mem_cmd_ready_o)
    else begin
      protocol_errors++;
      $display("protocol error: command ready while a command is in flight");
    end

  assert property (@(posedge clk_i) disable iff (reset_i) mem_resp_v_o |-> !cyc_o)
    else begin
      protocol_errors++;
      $display("protocol error: bus cycle active while a response is pending");
    end

  // bus cycle and stb run bookkeeping
  always @(posedge clk_i) begin
    if (reset_i) begin
      accepted <= 0;
      bus_cycles <= 0;
      stb_run <= 0;
      last_stb_len <= 0;
      cyc_q <= 1'b0;
    end else begin
      cyc_q <= cyc_o;
      if (cyc_o && !cyc_q) bus_cycles <= bus_cycles + 1;
      if (mem_cmd_v_i && mem_cmd_ready_o) accepted <= accepted + 1;
      if (stb_o) begin
        stb_run <= stb_run + 1;
      end else if (stb_run != 0) begin
        last_stb_len <= stb_run;
        stb_run <= 0;
      end
    end
  end

  function automatic wb_word_t initial_word(input int unsigned i);
    return {32'(i) ^ 32'hc0de_0000, ~32'(i)};
  endfunction

  // low bytes repeated over the whole word
  function automatic wb_word_t replicate(input wb_word_t word, input int unsigned bytes);
    wb_word_t result;
    for (int i = 0; i < 8; i++) begin
      result[i*8 +: 8] = word[(i % bytes)*8 +: 8];
    end
    return result;
  endfunction

  function automatic logic [31:0] random_addr(input int unsigned size_log2);
    int unsigned ofs;
    ofs = $urandom_range(0, 7) & ~((1 << size_log2) - 1);
    return 32'(($urandom_range(0, depth_lp - 1) << 3) | ofs);
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic print_error_counts();
    $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatches, protocol_errors, timeouts);
  endtask

  task automatic stop_on_timeout(input string why);
    timeouts++;
    $display("timeout in %s: %s", test_name, why);
    print_error_counts();
    $display("Errors found");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual)
      else begin
        mismatches++;
        $display("mismatch [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
      end
  endtask

  task automatic run_command(input mem_msg_type_e kind, input int unsigned size_log2,
                             input logic [31:0] addr, input wb_word_t wdata);
    mem_header_s hdr;
    exp_resp_s   exp;
    int unsigned idx, bytes, waited;
    bytes = 1 << size_log2;
    idx = (addr >> 3) % depth_lp;
    hdr = '{msg_type: kind, size: mem_msg_size_e'(size_log2), addr: addr};
    exp_sel = wb_sel_t'((1 << bytes) - 1);
    exp_adr = wb_adr_t'(addr >> 3);
    exp_we = (kind == e_uc_wr);
    exp_dat = wdata;
    exp.header = hdr;
    exp.err = hang;
    exp.data_known = (kind == e_uc_rd) || hang;
    exp.data = hang ? '0 : replicate(model_mem[idx], bytes);
    if (kind == e_uc_wr && !hang) begin
      for (int b = 0; b < bytes; b++) model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
    end
    exp_q.push_back(exp);

    mem_cmd_header_i = hdr;
    mem_cmd_data_i = wdata;
    mem_cmd_v_i = 1'b1;
    waited = 0;
    while (!mem_cmd_ready_o) begin
      next_cycle();
      waited++;
      if (waited == wait_limit_lp) stop_on_timeout("command never accepted");
    end
    next_cycle();
    mem_cmd_v_i = 1'b0;
    waited = 0;
    while (!mem_resp_v_o) begin
      next_cycle();
      waited++;
      if (waited == wait_limit_lp) stop_on_timeout("no response for the command");
    end
    // hold yumi off for a while
    repeat ($urandom_range(0, 4)) next_cycle();
    exp = exp_q.pop_front();
    check_value("response header", 64'(exp.header), 64'(mem_resp_header_o));
    check_value("response err", 64'(exp.err), 64'(mem_resp_err_o));
    if (exp.data_known) check_value("response data", exp.data, mem_resp_data_o);
    mem_resp_yumi_i = 1'b1;
    next_cycle();
    mem_resp_yumi_i = 1'b0;
  endtask

  initial begin
    logic [31:0] addr;
    void'($urandom(32'h38d6b701));
    reset_i = 1'b1;
    hang = 1'b0;
    mem_cmd_header_i = '0;
    mem_cmd_data_i = '0;
    mem_cmd_v_i = 1'b0;
    mem_resp_yumi_i = 1'b0;
    exp_sel = '0;
    exp_adr = '0;
    exp_we = 1'b0;
    exp_dat = '0;
    for (int i = 0; i < depth_lp; i++) model_mem[i] = initial_word(i);
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    next_cycle();

    test_name = "after reset";
    check_value("cyc_o", 64'd0, 64'(cyc_o));
    check_value("stb_o", 64'd0, 64'(stb_o));
    check_value("mem_resp_v_o", 64'd0, 64'(mem_resp_v_o));
    check_value("mem_cmd_ready_o", 64'd1, 64'(mem_cmd_ready_o));

    test_name = "write then read";
    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 3; k++) begin
        addr = random_addr(s);
        run_command(e_uc_wr, s, addr, {$urandom, $urandom});
        run_command(e_uc_rd, 3, addr & ~32'h7, '0);
      end
    end

    test_name = "narrow reads";
    for (int k = 0; k < 12; k++) begin
      addr = random_addr(k % 3);
      run_command(e_uc_rd, k % 3, addr, '0);
    end

    test_name = "ack timeout";
    hang = 1'b1;
    run_command(e_uc_rd, 3, random_addr(3), '0);
    hang = 1'b0;
    check_value("stb cycles before timeout", 64'(`WB_ACK_TIMEOUT), 64'(last_stb_len));
    run_command(e_uc_rd, 2, random_addr(2), '0);

    test_name = "bus cycle count";
    check_value("bus cycles per command", 64'(accepted), 64'(bus_cycles));
    print_error_counts();
    if (mismatches + protocol_errors + timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: testbench/wb_slave_model.sv
/* Wishbone classic slave, registered ack after 0 to 3 wait cycles
   memory is indexed by the low word address bits, hang_i suppresses ack */
`timescale 1ns/1ps

module wb_slave_model #(
  parameter int unsigned depth_p = 256
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  hang_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  wb_bus_pkg::wb_adr_t   adr_i,
  input  wb_bus_pkg::wb_sel_t   sel_i,
  input  wb_bus_pkg::wb_word_t  dat_i,
  output wb_bus_pkg::wb_word_t  dat_o,
  output logic                  ack_o
);

  import wb_bus_pkg::*;

  localparam int unsigned lanes_lp = $bits(wb_word_t) / 8;

  wb_word_t    mem [depth_p];
  logic        busy, rst_s, req_s, ack_s, we_s;
  wb_adr_t     adr_s;
  wb_sel_t     sel_s;
  wb_word_t    dat_s;
  int unsigned wait_left, idx;

  initial begin
    ack_o = 1'b0;
    dat_o = '0;
    busy = 1'b0;
    wait_left = 0;
    for (int i = 0; i < depth_p; i++) begin
      mem[i] = {32'(i) ^ 32'hc0de_0000, ~32'(i)};
    end
    forever begin
      @(posedge clk_i);
      // bus seen as the bridge sees it at this edge
      rst_s = reset_i;
      req_s = cyc_i & stb_i;
      ack_s = ack_o;
      we_s  = we_i;
      adr_s = adr_i;
      sel_s = sel_i;
      dat_s = dat_i;
      #1;
      ack_o = 1'b0;
      if (rst_s || !req_s || ack_s) begin
        busy = 1'b0;
      end else if (!busy) begin
        busy = 1'b1;
        wait_left = $urandom_range(0, 3);
      end else if (!hang_i) begin
        if (wait_left == 0) begin
          idx = adr_s % depth_p;
          if (we_s) begin
            for (int b = 0; b < lanes_lp; b++) begin
              if (sel_s[b]) mem[idx][b*8 +: 8] = dat_s[b*8 +: 8];
            end
          end else begin
            dat_o = mem[idx];
          end
          ack_o = 1'b1;
          busy = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

endmodule

// File: hdl/wb_master_bridge.sv
/* uncached memory commands to single Wishbone B4 classic cycles
   one command in flight, addresses must be aligned by the user */
`timescale 1ns/1ps

module wb_master_bridge (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // command side, valid/ready
  input  mem_msg_pkg::mem_header_s   mem_cmd_header_i,
  input  wb_bus_pkg::wb_word_t       mem_cmd_data_i,
  input  logic                       mem_cmd_v_i,
  output logic                       mem_cmd_ready_o,

  // response side, valid/yumi
  output mem_msg_pkg::mem_header_s   mem_resp_header_o,
  output wb_bus_pkg::wb_word_t       mem_resp_data_o,
  output logic                       mem_resp_err_o,
  output logic                       mem_resp_v_o,
  input  logic                       mem_resp_yumi_i,

  // Wishbone master
  output wb_bus_pkg::wb_adr_t        adr_o,
  output wb_bus_pkg::wb_word_t       dat_o,
  output wb_bus_pkg::wb_sel_t        sel_o,
  output logic                       we_o,
  output logic                       cyc_o,
  output logic                       stb_o,
  input  wb_bus_pkg::wb_word_t       dat_i,
  input  logic                       ack_i
);

  import mem_msg_pkg::*;
  import wb_bus_pkg::*;

  one_entry_if #(.payload_t(mem_cmd_s)) cmd_if ();
  one_entry_if #(.payload_t(wb_word_t)) resp_if ();

  wb_word_t packed_data;
  logic     resp_valid;
  logic     resp_zero;
  logic     timer_run;
  logic     timer_expired;

  // command enters straight from the ports
  assign cmd_if.in_data  = '{header: mem_cmd_header_i, data: mem_cmd_data_i};
  assign cmd_if.in_v     = mem_cmd_v_i;
  assign mem_cmd_ready_o = cmd_if.ready;

  // one yumi retires command and response together
  assign cmd_if.yumi  = mem_resp_yumi_i;
  assign resp_if.yumi = mem_resp_yumi_i;

  one_entry_buffer #(.payload_t(mem_cmd_s)) cmd_buffer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .buf_io (cmd_if.buffer)
  );

  resp_data_pack resp_pack (
    .data_i(dat_i),
    .size_i(cmd_if.out_data.header.size),
    .data_o(packed_data)
  );

  // timeout answers carry zero data
  assign resp_if.in_data = resp_zero ? '0 : packed_data;
  assign resp_if.in_v    = resp_valid;

  one_entry_buffer #(.payload_t(wb_word_t)) resp_buffer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .buf_io (resp_if.buffer)
  );

  ack_wait_timer ack_timer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .run_i    (timer_run),
    .expired_o(timer_expired)
  );

  wb_cycle_fsm cycle_fsm (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_io      (cmd_if.consumer),
    .resp_valid_o(resp_valid),
    .resp_zero_o (resp_zero),
    .resp_err_o  (mem_resp_err_o),
    .ack_i       (ack_i),
    .expired_i   (timer_expired),
    .timer_run_o (timer_run),
    .adr_o       (adr_o),
    .dat_o       (dat_o),
    .sel_o       (sel_o),
    .we_o        (we_o),
    .cyc_o       (cyc_o),
    .stb_o       (stb_o)
  );

  // header comes back from the held command
  assign mem_resp_header_o = cmd_if.out_data.header;
  assign mem_resp_data_o   = resp_if.out_data;
  assign mem_resp_v_o      = resp_if.out_v;

endmodule

// File: hdl/wb_cycle_fsm.sv
/* drives one Wishbone classic cycle per held command, no bursts
   ack wins over expiry in the same cycle, expiry answers with zero data */
`timescale 1ns/1ps

module wb_cycle_fsm (
  input  logic                  clk_i,
  input  logic                  reset_i,
  one_entry_if.consumer         cmd_io,
  output logic                  resp_valid_o,
  output logic                  resp_zero_o,
  output logic                  resp_err_o,
  input  logic                  ack_i,
  input  logic                  expired_i,
  output logic                  timer_run_o,
  output wb_bus_pkg::wb_adr_t   adr_o,
  output wb_bus_pkg::wb_word_t  dat_o,
  output wb_bus_pkg::wb_sel_t   sel_o,
  output logic                  we_o,
  output logic                  cyc_o,
  output logic                  stb_o
);

  import mem_msg_pkg::*;
  import wb_bus_pkg::*;

  localparam int unsigned offset_lp = $clog2($bits(wb_word_t) / 8);

  typedef enum logic [1:0] {
    e_reset     = 2'b00,
    e_idle      = 2'b01,
    e_bus_wait  = 2'b10,
    e_resp_wait = 2'b11
  } state_e;

  state_e      state_r;
  state_e      state_n;
  logic        err_r;
  mem_header_s hdr;

  assign hdr = cmd_io.out_data.header;

  // bus fields follow the held command directly
  assign adr_o = wb_adr_t'(hdr.addr >> offset_lp);
  assign dat_o = cmd_io.out_data.data;
  assign we_o  = (hdr.msg_type == e_uc_wr);

  always_comb begin
    unique case (hdr.size)
      e_size_1: sel_o = wb_sel_t'('h1);
      e_size_2: sel_o = wb_sel_t'('h3);
      e_size_4: sel_o = wb_sel_t'('hF);
      default:  sel_o = '1;
    endcase
  end

  always_comb begin
    state_n      = state_r;
    cyc_o        = 1'b0;
    stb_o        = 1'b0;
    resp_valid_o = 1'b0;
    resp_zero_o  = 1'b0;

    unique case (state_r)
      e_reset: begin
        state_n = e_idle;
      end

      // cycle opens in the same cycle the command shows up
      e_idle, e_bus_wait: begin
        cyc_o = (state_r == e_bus_wait) | cmd_io.out_v;
        stb_o = cyc_o;
        if (stb_o) begin
          resp_valid_o = ack_i | expired_i;
          resp_zero_o  = ~ack_i & expired_i;
          state_n      = (ack_i | expired_i) ? e_resp_wait : e_bus_wait;
        end
      end

      // response held until yumi frees both buffers
      e_resp_wait: begin
        if (cmd_io.yumi) begin
          state_n = e_idle;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

  // error travels with the response slot
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_r <= 1'b0;
    end else if (resp_zero_o) begin
      err_r <= 1'b1;
    end else if (cmd_io.yumi) begin
      err_r <= 1'b0;
    end
  end

  assign resp_err_o  = err_r;
  assign timer_run_o = stb_o;

endmodule

// File: hdl/ack_wait_timer.sv
/* counts consecutive run cycles, expired_o marks the last allowed one
   the count clears as soon as run_i drops */
`timescale 1ns/1ps
`include "wb_bridge_consts.svh"

module ack_wait_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic run_i,
  output logic expired_o
);

  localparam int unsigned limit_lp = `WB_ACK_TIMEOUT;
  localparam int unsigned cnt_w_lp = $clog2(limit_lp + 1);

  logic [cnt_w_lp-1:0] count_r;

  // one tick per cycle spent waiting
  always_ff @(posedge clk_i) begin
    if (reset_i || !run_i) begin
      count_r <= '0;
    end else begin
      count_r <= count_r + cnt_w_lp'(1);
    end
  end

  // count_r holds the cycles already waited, so this is cycle limit_lp
  assign expired_o = run_i & (count_r == cnt_w_lp'(limit_lp - 1));

endmodule

// File: hdl/resp_data_pack.sv
/* repeats the low 2^size bytes of a read word across the whole bus word
   the narrow data is expected in the lowest byte lanes */
`timescale 1ns/1ps

module resp_data_pack (
  input  wb_bus_pkg::wb_word_t        data_i,
  input  mem_msg_pkg::mem_msg_size_e  size_i,
  output wb_bus_pkg::wb_word_t        data_o
);

  import mem_msg_pkg::*;
  import wb_bus_pkg::*;

  localparam int unsigned lanes_lp  = $bits(wb_word_t) / 8;
  localparam int unsigned lane_w_lp = $clog2(lanes_lp);

  logic [lane_w_lp-1:0] lane_mask;

  // which low lanes are meaningful for this size
  always_comb begin
    unique case (size_i)
      e_size_1: lane_mask = '0;
      e_size_2: lane_mask = lane_w_lp'(1);
      e_size_4: lane_mask = lane_w_lp'(3);
      default:  lane_mask = '1;
    endcase
  end

  // each output lane copies its source lane modulo the size
  always_comb begin
    for (int lane = 0; lane < lanes_lp; lane++) begin
      data_o[lane*8 +: 8] = data_i[(lane & lane_mask)*8 +: 8];
    end
  end

endmodule

// File: hdl/one_entry_buffer.sv
/* single-slot buffer, ready is low while the slot is full
   yumi must only be raised while out_v is high */
`timescale 1ns/1ps

module one_entry_buffer #(
  parameter type payload_t = logic
) (
  input  logic          clk_i,
  input  logic          reset_i,
  one_entry_if.buffer   buf_io
);

  logic     full_r;
  payload_t data_r;
  logic     fill;

  assign fill = buf_io.in_v & buf_io.ready;

  // occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (fill) begin
      full_r <= 1'b1;
    end else if (buf_io.yumi) begin
      full_r <= 1'b0;
    end
  end

  // payload only moves on a fill
  always_ff @(posedge clk_i) begin
    if (fill) begin
      data_r <= buf_io.in_data;
    end
  end

  assign buf_io.ready    = ~full_r;
  assign buf_io.out_v    = full_r;
  assign buf_io.out_data = data_r;

endmodule

// File: hdl/one_entry_if.sv
/* signals around a one-entry buffer, payload type set per instance
   consumer side only observes yumi, it is driven by the owner */
`timescale 1ns/1ps

interface one_entry_if #(
  parameter type payload_t = logic
) ();

  // fill side
  payload_t in_data;
  logic     in_v;
  logic     ready;

  // drain side
  payload_t out_data;
  logic     out_v;
  logic     yumi;

  modport producer (
    output in_data, in_v,
    input  ready
  );

  modport consumer (
    input out_data, out_v, yumi
  );

  modport buffer (
    input  in_data, in_v, yumi,
    output ready, out_data, out_v
  );

endinterface

// File: hdl/wb_bus_pkg.sv
/* Wishbone B4 classic bus types, word addressed */
`include "wb_bridge_consts.svh"

package wb_bus_pkg;

  // one full bus word
  typedef logic [`WB_DATA_WIDTH-1:0] wb_word_t;

  // one select bit per byte lane
  typedef logic [`WB_DATA_WIDTH/8-1:0] wb_sel_t;

  // byte address with the in-word offset bits removed
  typedef logic [`WB_PADDR_WIDTH-$clog2(`WB_DATA_WIDTH/8)-1:0] wb_adr_t;

endpackage

// File: hdl/mem_msg_pkg.sv
/* processor-side memory message types, uncached only
   addresses are assumed aligned to the message size */
`include "wb_bridge_consts.svh"

package mem_msg_pkg;

  // only the two uncached types are carried
  typedef enum logic {
    e_uc_rd = 1'b0,
    e_uc_wr = 1'b1
  } mem_msg_type_e;

  // log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } mem_msg_size_e;

  typedef struct packed {
    mem_msg_type_e                 msg_type;
    mem_msg_size_e                 size;
    logic [`WB_PADDR_WIDTH-1:0]    addr;
  } mem_header_s;

  // header plus one bus word, what the command buffer holds
  typedef struct packed {
    mem_header_s                   header;
    logic [`WB_DATA_WIDTH-1:0]     data;
  } mem_cmd_s;

endpackage

// File: include/wb_bridge_consts.svh
/* bus geometry and ack timeout for the Wishbone bridge
   data width must be a power of two bytes, at most 64 bits */
`ifndef WB_BRIDGE_CONSTS_SVH
`define WB_BRIDGE_CONSTS_SVH

// bus word width in bits
`define WB_DATA_WIDTH 64

// physical byte address width
`define WB_PADDR_WIDTH 32

// stb cycles without ack before the cycle is abandoned
`define WB_ACK_TIMEOUT 16

`endif
